/* Makefile */
VERILATOR = verilator
TOP = tb_top
FILELIST = tb.f
BUILD_DIR = obj_dir
LOG = sim.log
FLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only -Wall --timing --top-module $(TOP)
PASS_TEXT = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb.f */
verilog/tetris_pkg.sv
verilog/drop_timer.sv
verilog/board_store.sv
verilog/board_arbiter.sv
verilog/piece_control.sv
verilog/row_clear.sv
verilog/seg_display.sv
verilog/tetris_top.sv
tb/tb_checker.sv
tb/tb_top.sv

/* tb/tb_checker.sv */
module tb_checker #(
	parameter int level1_period = 40,
	parameter int level2_period = 30,
	parameter int level3_period = 20
) (
	input logic clk,
	input logic reset,
	input logic left,
	input logic right,
	input logic sw9,
	input logic sw8,
	input tetris_pkg::seg_t hex0,
	input tetris_pkg::seg_t hex1,
	input tetris_pkg::seg_t hex2,
	input tetris_pkg::seg_t hex3,
	output logic model_tick,
	output logic model_over,
	output int checks,
	output int errors
);

	localparam int mode_idle = 0;
	localparam int mode_falling = 1;
	localparam int mode_over = 2;

	logic [2:0] board [4];
	int count;
	int mode;
	int piece_d;
	int piece_l;
	int spawn_l;
	int since_tick;
	logic left_latch;
	logic right_latch;
	logic fire;
	logic [27:0] shown;
	logic [27:0] prev_shown;

	assign model_over = (mode == mode_over);

	function automatic int selected_period(input logic s9, input logic s8);
		if (s8)
			return level3_period;
		else if (s9)
			return level2_period;
		return level1_period;
	endfunction

	// lane 0 on a, lane 1 on g, lane 2 on d, lit means 0
	function automatic tetris_pkg::seg_t expected_digit(input int d);
		logic [2:0] cells;
		tetris_pkg::seg_t seg;
		cells = board[d];
		if (mode == mode_falling && piece_d == d)
			cells[piece_l] = 1'b1;
		seg = 7'h7f;
		seg[tetris_pkg::seg_a] = !cells[0];
		seg[tetris_pkg::seg_g] = !cells[1];
		seg[tetris_pkg::seg_d] = !cells[2];
		if (mode == mode_over)
			seg = tetris_pkg::game_over_pattern[d];
		return seg;
	endfunction

	task automatic compare_display();
		tetris_pkg::seg_t want;
		tetris_pkg::seg_t got;
		int d;
		for (d = 0; d < tetris_pkg::num_digits; d++) begin
			want = expected_digit(d);
			got = shown[d*7 +: 7];
			checks++;
			if (got !== want) begin
				errors++;
				$display("FAIL %0t: hex%0d is %b, model expects %b", $time, d, got, want);
			end
		end
	endtask

	// recheck the same digit after each collapse
	task automatic clear_full_digits();
		int k;
		int d;
		k = 3;
		while (k >= 0) begin
			if (board[k] == 3'b111) begin
				for (d = k; d > 0; d--)
					board[d] = board[d-1];
				board[0] = 3'b000;
			end else begin
				k--;
			end
		end
	endtask

	task automatic spawn_piece();
		if (board[0][spawn_l]) begin
			mode = mode_over;
		end else begin
			mode = mode_falling;
			piece_d = 0;
			piece_l = spawn_l;
			spawn_l = (spawn_l + 1) % 3;
		end
	endtask

	// lock, clear and respawn all finish well inside one tick
	task automatic apply_tick();
		int lane;
		if (mode == mode_idle) begin
			spawn_piece();
		end else if (mode == mode_falling) begin
			lane = piece_l;
			if (right_latch && lane < 2 && !board[piece_d][lane+1])
				lane = lane + 1;
			if (left_latch && lane > 0 && !board[piece_d][lane-1])
				lane = lane - 1;
			piece_l = lane;
			left_latch = 1'b0;
			right_latch = 1'b0;
			if (piece_d < 3 && !board[piece_d+1][lane]) begin
				piece_d = piece_d + 1;
			end else begin
				board[piece_d][lane] = 1'b1;
				clear_full_digits();
				spawn_piece();
			end
		end
	endtask

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			count = 0;
			model_tick = 1'b0;
			mode = mode_idle;
			board = '{default: 3'b000};
			piece_d = 0;
			piece_l = 0;
			spawn_l = 0;
			left_latch = 1'b0;
			right_latch = 1'b0;
			since_tick = 0;
			prev_shown = {4{tetris_pkg::seg_dark}};
		end else begin
			fire = model_tick;
			if (count == selected_period(sw9, sw8)) begin
				count = 0;
				model_tick = 1'b1;
			end else begin
				count = count + 1;
				model_tick = 1'b0;
			end
			shown = {hex3, hex2, hex1, hex0};
			if (fire) begin
				compare_display();
				apply_tick();
				since_tick = 0;
			end else begin
				// late in the tick interval the display must hold still
				if (since_tick > 16 && shown !== prev_shown) begin
					errors++;
					$display("FAIL %0t: display changed %0d cycles after the last tick",
						$time, since_tick);
				end
				since_tick++;
			end
			prev_shown = shown;
			left_latch = left_latch || !left;
			right_latch = right_latch || !right;
		end
	end

endmodule

/* tb/tb_top.sv */
module tb_top;

	localparam int level1_period = 40;
	localparam int level2_period = 30;
	localparam int level3_period = 20;
	localparam int total_ticks = 400;
	// slowest tick spacing with a 10 percent margin
	localparam int cycle_limit = total_ticks * (level1_period + 1) * 11 / 10;

	logic clk;
	logic reset;
	logic left;
	logic right;
	logic sw9;
	logic sw8;
	tetris_pkg::seg_t hex0;
	tetris_pkg::seg_t hex1;
	tetris_pkg::seg_t hex2;
	tetris_pkg::seg_t hex3;
	logic model_tick;
	logic model_over;
	int checks;
	int errors;
	int seed;
	int ticks_seen;
	int over_ticks;
	int cycles = 0;
	logic reset_pulsed;

	tetris_top #(
		.level1_period(tetris_pkg::period_t'(level1_period)),
		.level2_period(tetris_pkg::period_t'(level2_period)),
		.level3_period(tetris_pkg::period_t'(level3_period))
	) UUT (
		.clk(clk), .reset(reset), .left(left), .right(right),
		.sw9(sw9), .sw8(sw8),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3)
	);

	tb_checker #(
		.level1_period(level1_period),
		.level2_period(level2_period),
		.level3_period(level3_period)
	) u_checker (
		.clk(clk), .reset(reset), .left(left), .right(right),
		.sw9(sw9), .sw8(sw8),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
		.model_tick(model_tick), .model_over(model_over),
		.checks(checks), .errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// each button low for one cycle, about one cycle in 8
	task automatic drive_buttons();
		left = ({$random(seed)} % 8) != 0;
		right = ({$random(seed)} % 8) != 0;
	endtask

	// only right after a tick, so the count never runs past a shorter period
	task automatic change_level();
		int level;
		if (({$random(seed)} % 10) == 0) begin
			level = {$random(seed)} % 3;
			sw9 = (level == 1) || (level == 2 && ({$random(seed)} % 2) == 1);
			sw8 = (level == 2);
		end
	endtask

	task automatic pulse_reset();
		reset = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b1;
		reset_pulsed = 1'b1;
	endtask

	initial begin
		seed = 16;
		reset = 1'b0;
		left = 1'b1;
		right = 1'b1;
		sw9 = 1'b0;
		sw8 = 1'b0;
		ticks_seen = 0;
		over_ticks = 0;
		reset_pulsed = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b1;
		while (ticks_seen < total_ticks) begin
			@(negedge clk);
			drive_buttons();
			if (model_tick) begin
				ticks_seen++;
				change_level();
				if (model_over && !reset_pulsed)
					over_ticks++;
				// let the game-over screen show for a few ticks first
				if (over_ticks == 4 && !reset_pulsed)
					pulse_reset();
			end
		end
		// the last tick is compared on the following rising edge
		@(negedge clk);
		$display("ticks %0d, checks %0d, errors %0d", ticks_seen, checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: only %0d of %0d ticks after %0d cycles",
				ticks_seen, total_ticks, cycles);
			$display("ticks %0d, checks %0d, errors %0d", ticks_seen, checks, errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

/* verilog/board_arbiter.sv */
module board_arbiter (
	input logic clk,
	input logic reset,
	input logic lock_valid,
	input tetris_pkg::digit_idx_t lock_digit,
	input tetris_pkg::lane_idx_t lock_lane,
	output logic lock_ready,
	input logic shift_valid,
	input tetris_pkg::digit_idx_t shift_digit,
	input tetris_pkg::digit_t shift_data,
	output logic shift_ready,
	output logic wr_en,
	output tetris_pkg::digit_idx_t wr_digit,
	output tetris_pkg::lane_idx_t wr_set_lane,
	output logic wr_is_set,
	output tetris_pkg::digit_t wr_data
);

	// row clearer has priority and the store takes a write every cycle
	assign shift_ready = shift_valid;
	assign lock_ready = lock_valid && !shift_valid;

	assign wr_en = shift_ready || lock_ready;
	assign wr_is_set = lock_ready;
	assign wr_digit = shift_ready ? shift_digit : lock_digit;
	assign wr_set_lane = lock_lane;
	assign wr_data = shift_data;

	// a waiting lock request stays up with the same cell
	lock_held: assert property (
		@(posedge clk) disable iff (!reset)
		lock_valid && !lock_ready |=> lock_valid && $stable({lock_digit, lock_lane})
	);

endmodule

/* verilog/board_store.sv */
module board_store (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input tetris_pkg::digit_idx_t wr_digit,
	input tetris_pkg::lane_idx_t wr_set_lane,
	input logic wr_is_set,
	input tetris_pkg::digit_t wr_data,
	output tetris_pkg::digit_t [tetris_pkg::num_digits-1:0] board_q
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			board_q <= '0;
		end else if (wr_en) begin
			// lock sets one cell, shift replaces the digit
			if (wr_is_set)
				board_q[wr_digit][wr_set_lane] <= 1'b1;
			else
				board_q[wr_digit] <= wr_data;
		end
	end

	// a lock never points past the last lane
	set_lane_in_range: assert property (
		@(posedge clk) disable iff (!reset)
		wr_en && wr_is_set |-> wr_set_lane < tetris_pkg::num_lanes
	);

endmodule

/* verilog/drop_timer.sv */
module drop_timer (
	input logic clk,
	input logic reset,
	input logic sw9,
	input logic sw8,
	input tetris_pkg::period_t level1_period,
	input tetris_pkg::period_t level2_period,
	input tetris_pkg::period_t level3_period,
	output logic tick
);

	tetris_pkg::period_t period;
	tetris_pkg::period_t count;

	// sw8 wins over sw9
	always_comb begin
		if (sw8)
			period = level3_period;
		else if (sw9)
			period = level2_period;
		else
			period = level1_period;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= '0;
			tick <= 1'b0;
		end else if (count == period) begin
			count <= '0;
			tick <= 1'b1;
		end else begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

/* verilog/piece_control.sv */
module piece_control (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic left,
	input logic right,
	input tetris_pkg::digit_t [tetris_pkg::num_digits-1:0] board_q,
	input logic clear_done,
	output logic lock_valid,
	output tetris_pkg::digit_idx_t lock_digit,
	output tetris_pkg::lane_idx_t lock_lane,
	input logic lock_ready,
	output logic clear_start,
	output tetris_pkg::digit_idx_t piece_digit,
	output tetris_pkg::lane_idx_t piece_lane,
	output logic piece_shown,
	output logic game_over
);

	tetris_pkg::piece_state_t state;
	tetris_pkg::lane_idx_t spawn_lane;
	tetris_pkg::lane_idx_t right_lane;
	tetris_pkg::lane_idx_t left_lane;
	tetris_pkg::lane_idx_t moved_lane;
	tetris_pkg::digit_idx_t below_digit;
	logic left_held;
	logic right_held;
	logic take_tick;
	logic can_fall;
	logic spawn_req;
	logic spawn_blocked;

	assign take_tick = tick && state == tetris_pkg::piece_falling;
	assign spawn_req = (tick && state == tetris_pkg::piece_idle) ||
		(clear_done && state == tetris_pkg::piece_clearing);
	assign spawn_blocked = board_q[0][spawn_lane];

	// right is tried first, then left from wherever right left us
	always_comb begin
		right_lane = piece_lane + 2'd1;
		moved_lane = piece_lane;
		if (right_held && piece_lane != tetris_pkg::lane_d && !board_q[piece_digit][right_lane])
			moved_lane = right_lane;
		left_lane = moved_lane - 2'd1;
		if (left_held && moved_lane != tetris_pkg::lane_a && !board_q[piece_digit][left_lane])
			moved_lane = left_lane;
	end

	assign below_digit = piece_digit + 2'd1;
	assign can_fall = piece_digit != 2'd3 && !board_q[below_digit][moved_lane];

	assign lock_valid = state == tetris_pkg::piece_locking;
	assign lock_digit = piece_digit;
	assign lock_lane = piece_lane;
	assign piece_shown = state == tetris_pkg::piece_falling || lock_valid;
	assign game_over = state == tetris_pkg::piece_over;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= tetris_pkg::piece_idle;
			piece_digit <= '0;
			piece_lane <= tetris_pkg::lane_a;
			spawn_lane <= tetris_pkg::lane_a;
			left_held <= 1'b0;
			right_held <= 1'b0;
			clear_start <= 1'b0;
		end else begin
			clear_start <= 1'b0;
			// a press in the tick cycle itself waits for the next tick
			left_held <= (left_held && !take_tick) || !left;
			right_held <= (right_held && !take_tick) || !right;
			if (spawn_req) begin
				if (spawn_blocked) begin
					state <= tetris_pkg::piece_over;
				end else begin
					state <= tetris_pkg::piece_falling;
					piece_digit <= '0;
					piece_lane <= spawn_lane;
					if (spawn_lane == tetris_pkg::lane_d)
						spawn_lane <= tetris_pkg::lane_a;
					else
						spawn_lane <= spawn_lane + 2'd1;
				end
			end else if (take_tick) begin
				piece_lane <= moved_lane;
				if (can_fall)
					piece_digit <= below_digit;
				else
					state <= tetris_pkg::piece_locking;
			end else if (lock_valid && lock_ready) begin
				state <= tetris_pkg::piece_clearing;
				clear_start <= 1'b1;
			end
		end
	end

	lane_in_range: assert property (
		@(posedge clk) disable iff (!reset)
		piece_lane <= tetris_pkg::lane_d
	);

endmodule

/* verilog/row_clear.sv */
module row_clear (
	input logic clk,
	input logic reset,
	input logic clear_start,
	input tetris_pkg::digit_t [tetris_pkg::num_digits-1:0] board_q,
	output logic shift_valid,
	output tetris_pkg::digit_idx_t shift_digit,
	output tetris_pkg::digit_t shift_data,
	input logic shift_ready,
	output logic clear_done
);

	tetris_pkg::clear_state_t state;
	tetris_pkg::digit_idx_t full_digit;
	logic full_found;

	// lowest full digit wins
	always_comb begin
		full_found = 1'b0;
		full_digit = '0;
		for (int d = 0; d < tetris_pkg::num_digits; d++) begin
			if (&board_q[d]) begin
				full_found = 1'b1;
				full_digit = tetris_pkg::digit_idx_t'(d);
			end
		end
	end

	assign shift_valid = state == tetris_pkg::clear_shift;
	// digit 0 has nothing above it
	assign shift_data = (shift_digit == '0) ? '0 : board_q[shift_digit - 2'd1];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= tetris_pkg::clear_idle;
			shift_digit <= '0;
			clear_done <= 1'b0;
		end else begin
			clear_done <= 1'b0;
			case (state)
				tetris_pkg::clear_idle: begin
					if (clear_start)
						state <= tetris_pkg::clear_scan;
				end
				tetris_pkg::clear_scan: begin
					if (full_found) begin
						shift_digit <= full_digit;
						state <= tetris_pkg::clear_shift;
					end else begin
						clear_done <= 1'b1;
						state <= tetris_pkg::clear_idle;
					end
				end
				tetris_pkg::clear_shift: begin
					if (shift_ready) begin
						// walk upward, then look again
						if (shift_digit == '0)
							state <= tetris_pkg::clear_scan;
						else
							shift_digit <= shift_digit - 2'd1;
					end
				end
				default: state <= tetris_pkg::clear_idle;
			endcase
		end
	end

	shift_held: assert property (
		@(posedge clk) disable iff (!reset)
		shift_valid && !shift_ready |=> shift_valid && $stable(shift_digit)
	);

endmodule

/* verilog/seg_display.sv */
module seg_display (
	input logic clk,
	input logic reset,
	input tetris_pkg::digit_t [tetris_pkg::num_digits-1:0] board_q,
	input tetris_pkg::digit_idx_t piece_digit,
	input tetris_pkg::lane_idx_t piece_lane,
	input logic piece_shown,
	input logic game_over,
	output tetris_pkg::seg_t hex0,
	output tetris_pkg::seg_t hex1,
	output tetris_pkg::seg_t hex2,
	output tetris_pkg::seg_t hex3
);

	tetris_pkg::digit_t lit [tetris_pkg::num_digits];
	tetris_pkg::seg_t next_seg [tetris_pkg::num_digits];

	// only a, g and d ever light during play
	function automatic tetris_pkg::seg_t cells_to_seg(input tetris_pkg::digit_t cells);
		tetris_pkg::seg_t seg;
		seg = tetris_pkg::seg_dark;
		seg[tetris_pkg::seg_a] = !cells[tetris_pkg::lane_a];
		seg[tetris_pkg::seg_g] = !cells[tetris_pkg::lane_g];
		seg[tetris_pkg::seg_d] = !cells[tetris_pkg::lane_d];
		return seg;
	endfunction

	always_comb begin
		for (int d = 0; d < tetris_pkg::num_digits; d++) begin
			lit[d] = board_q[d];
			if (piece_shown && piece_digit == d)
				lit[d][piece_lane] = 1'b1;
			if (game_over)
				next_seg[d] = tetris_pkg::game_over_pattern[d];
			else
				next_seg[d] = cells_to_seg(lit[d]);
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			hex0 <= tetris_pkg::seg_dark;
			hex1 <= tetris_pkg::seg_dark;
			hex2 <= tetris_pkg::seg_dark;
			hex3 <= tetris_pkg::seg_dark;
		end else begin
			hex0 <= next_seg[0];
			hex1 <= next_seg[1];
			hex2 <= next_seg[2];
			hex3 <= next_seg[3];
		end
	end

endmodule

/* verilog/tetris_pkg.sv */
package tetris_pkg;

	// board geometry
	localparam int num_digits = 4;
	localparam int num_lanes = 3;

	typedef logic [2:0] digit_t;
	typedef logic [1:0] digit_idx_t;
	typedef logic [1:0] lane_idx_t;
	typedef logic [6:0] seg_t;
	typedef logic [25:0] period_t;

	typedef enum logic [2:0] {
		piece_idle,
		piece_falling,
		piece_locking,
		piece_clearing,
		piece_over
	} piece_state_t;

	typedef enum logic [1:0] {
		clear_idle,
		clear_scan,
		clear_shift
	} clear_state_t;

	// lane order, top to bottom within a digit
	localparam lane_idx_t lane_a = 2'd0;
	localparam lane_idx_t lane_g = 2'd1;
	localparam lane_idx_t lane_d = 2'd2;

	// bit positions in seg_t, bit 0 is segment a
	localparam int seg_a = 0;
	localparam int seg_d = 3;
	localparam int seg_g = 6;

	localparam seg_t seg_dark = 7'h7f;

	// reads LOSE from hex3 down to hex0
	localparam seg_t game_over_pattern [num_digits] = '{
		7'b0000110, 7'b0010010, 7'b1000000, 7'b1000111
	};

endpackage

/* verilog/tetris_top.sv */
module tetris_top #(
	parameter tetris_pkg::period_t level1_period = 26'd50_000_000,
	parameter tetris_pkg::period_t level2_period = 26'd37_500_000,
	parameter tetris_pkg::period_t level3_period = 26'd25_000_000
) (
	input logic clk,
	input logic reset,
	input logic left,
	input logic right,
	input logic sw9,
	input logic sw8,
	output tetris_pkg::seg_t hex0,
	output tetris_pkg::seg_t hex1,
	output tetris_pkg::seg_t hex2,
	output tetris_pkg::seg_t hex3
);

	tetris_pkg::digit_t [tetris_pkg::num_digits-1:0] board_q;
	tetris_pkg::digit_idx_t lock_digit;
	tetris_pkg::lane_idx_t lock_lane;
	tetris_pkg::digit_idx_t shift_digit;
	tetris_pkg::digit_t shift_data;
	tetris_pkg::digit_idx_t wr_digit;
	tetris_pkg::lane_idx_t wr_set_lane;
	tetris_pkg::digit_t wr_data;
	tetris_pkg::digit_idx_t piece_digit;
	tetris_pkg::lane_idx_t piece_lane;
	logic tick;
	logic lock_valid;
	logic lock_ready;
	logic shift_valid;
	logic shift_ready;
	logic wr_en;
	logic wr_is_set;
	logic clear_start;
	logic clear_done;
	logic piece_shown;
	logic game_over;

	drop_timer u_drop_timer (
		.clk(clk), .reset(reset), .sw9(sw9), .sw8(sw8),
		.level1_period(level1_period), .level2_period(level2_period),
		.level3_period(level3_period), .tick(tick)
	);

	board_store u_board_store (
		.clk(clk), .reset(reset), .wr_en(wr_en), .wr_digit(wr_digit),
		.wr_set_lane(wr_set_lane), .wr_is_set(wr_is_set), .wr_data(wr_data),
		.board_q(board_q)
	);

	board_arbiter u_board_arbiter (
		.clk(clk), .reset(reset),
		.lock_valid(lock_valid), .lock_digit(lock_digit), .lock_lane(lock_lane),
		.lock_ready(lock_ready),
		.shift_valid(shift_valid), .shift_digit(shift_digit), .shift_data(shift_data),
		.shift_ready(shift_ready),
		.wr_en(wr_en), .wr_digit(wr_digit), .wr_set_lane(wr_set_lane),
		.wr_is_set(wr_is_set), .wr_data(wr_data)
	);

	piece_control u_piece_control (
		.clk(clk), .reset(reset), .tick(tick), .left(left), .right(right),
		.board_q(board_q), .clear_done(clear_done),
		.lock_valid(lock_valid), .lock_digit(lock_digit), .lock_lane(lock_lane),
		.lock_ready(lock_ready), .clear_start(clear_start),
		.piece_digit(piece_digit), .piece_lane(piece_lane),
		.piece_shown(piece_shown), .game_over(game_over)
	);

	row_clear u_row_clear (
		.clk(clk), .reset(reset), .clear_start(clear_start), .board_q(board_q),
		.shift_valid(shift_valid), .shift_digit(shift_digit), .shift_data(shift_data),
		.shift_ready(shift_ready), .clear_done(clear_done)
	);

	seg_display u_seg_display (
		.clk(clk), .reset(reset), .board_q(board_q),
		.piece_digit(piece_digit), .piece_lane(piece_lane),
		.piece_shown(piece_shown), .game_over(game_over),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3)
	);

endmodule
